// File: mem_system.f
design/cache_geom_pkg.sv
design/bank_mem_pkg.sv
design/cache_port_if.sv
design/mem_port_if.sv
design/storage_ram.sv
design/cache_array.sv
design/four_bank_mem.sv
design/cache_ctrl.sv
design/mem_system.sv
tb/mem_system_properties.sv
tb/mem_system_tb.sv

// File: Makefile
TOP := mem_system_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -Wno-fatal -f mem_system.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation completed successfully"

lint:
	verilator --lint-only -Wall --timing -f mem_system.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: tb/mem_system_tb.sv
module mem_system_tb import cache_geom_pkg::*, bank_mem_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int max_cycles = 6000;  // About 230 requests at up to 24 cycles plus reset
	localparam int num_random = 200;
	localparam int lines      = 1 << index_w;

	logic              clk;
	logic              rst_n;
	logic [addr_w-1:0] addr;
	word_t             data_in;
	logic              rd;
	logic              wr;
	word_t             data_out;
	logic              done;
	logic              stall;
	logic              cache_hit;
	logic              err;

	word_t            shadow [logic [addr_w-2:0]];  // Keyed by word address with unwritten words reading zero
	logic [tag_w-1:0] line_tag [lines];
	logic             line_valid [lines];
	logic             line_dirty [lines];
	int               errors;
	int               checks;
	int               write_backs;
	int               cycle_cnt;
	int               seed;

	mem_system #(.mem_words(32768)) uut (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Watchdog
	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < max_cycles) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Timeout: the run did not finish within %0d clock cycles", max_cycles);
		$display("Simulation failed");
		$finish;
	end

	task automatic report_mismatch(input string name, input int expected, input int actual);
		$display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
		errors++;
	endtask

	// One legal request held until done and through the closing edge
	task automatic access(input string name, input logic is_wr, input logic [addr_w-1:0] a,
		input word_t d);
		logic [addr_w-2:0]  key;
		logic [index_w-1:0] idx;
		logic [tag_w-1:0]   tg;
		logic               exp_hit;
		word_t              exp_data;
		int                 cycles;
		key      = a[addr_w-1:1];
		idx      = a[offset_w +: index_w];
		tg       = a[addr_w-1 -: tag_w];
		exp_hit  = line_valid[idx] && (line_tag[idx] == tg);
		exp_data = shadow.exists(key) ? shadow[key] : '0;
		addr     = a;
		data_in  = d;
		rd       = ~is_wr;
		wr       = is_wr;
		cycles   = 0;
		do begin
			@(negedge clk);
			cycles++;
			checks++;
			assert (stall === !done) else report_mismatch({name, " stall"}, int'(!done),
				int'(stall));
			assert (err === 1'b0) else report_mismatch({name, " err"}, 0, int'(err));
		end while (!done);
		checks++;
		assert (cache_hit === exp_hit) else report_mismatch({name, " hit"}, int'(exp_hit),
			int'(cache_hit));
		if (exp_hit) begin
			checks++;
			assert (cycles == 1) else report_mismatch({name, " hit latency"}, 1, cycles);
		end
		if (!is_wr) begin
			checks++;
			assert (data_out === exp_data) else report_mismatch({name, " data"}, int'(exp_data),
				int'(data_out));
		end
		if (!exp_hit && line_valid[idx] && line_dirty[idx]) begin
			write_backs++;  // Victim went back to memory
		end
		line_dirty[idx] = exp_hit ? (line_dirty[idx] | is_wr) : is_wr;
		line_valid[idx] = 1'b1;
		line_tag[idx]   = tg;
		if (is_wr) begin
			shadow[key] = d;
		end
		@(negedge clk);
		rd = 1'b0;
		wr = 1'b0;
	endtask

	task automatic illegal_request(input string name, input logic [addr_w-1:0] a,
		input logic r, input logic w);
		addr    = a;
		data_in = 16'hdead;
		rd      = r;
		wr      = w;
		repeat (3) begin
			@(negedge clk);
			checks++;
			assert (err === 1'b1) else report_mismatch({name, " err"}, 1, int'(err));
			assert (done === 1'b0) else report_mismatch({name, " done"}, 0, int'(done));
		end
		rd = 1'b0;
		wr = 1'b0;
	endtask

	initial begin
		logic [31:0] r;
		rst_n       = 1'b0;
		addr        = '0;
		data_in     = '0;
		rd          = 1'b0;
		wr          = 1'b0;
		errors      = 0;
		checks      = 0;
		write_backs = 0;
		seed        = 32'h2d7bf8c3;
		foreach (line_valid[i]) begin
			line_valid[i] = 1'b0;
			line_dirty[i] = 1'b0;
			line_tag[i]   = '0;
		end
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		repeat (2) @(negedge clk);

		access("first read", 1'b0, 16'h0000, 16'h0000);  // Must miss after reset
		access("same line", 1'b0, 16'h0004, 16'h0000);
		access("write miss", 1'b1, 16'h0010, 16'h1234);
		access("write hit", 1'b1, 16'h0012, 16'h5678);
		access("conflict", 1'b0, 16'h0810, 16'h0000);    // Same index evicts the dirty line
		access("reload a", 1'b0, 16'h0010, 16'h0000);
		access("reload a+2", 1'b0, 16'h0012, 16'h0000);
		illegal_request("odd read", 16'h0021, 1'b1, 1'b0);
		illegal_request("odd write", 16'h0013, 1'b0, 1'b1);
		illegal_request("rd and wr", 16'h0010, 1'b1, 1'b1);
		access("after illegal", 1'b0, 16'h0010, 16'h0000);
		access("after odd wr", 1'b0, 16'h0012, 16'h0000);
		access("merge write", 1'b1, 16'h0014, 16'habcd);
		access("merge read", 1'b0, 16'h0014, 16'h0000);

		// 8 tags over 4 indices
		for (int i = 0; i < num_random; i++) begin
			r = $random(seed);
			access($sformatf("random %0d", i), r[7],
				{2'b00, r[2:0], 6'd0, r[4:3], r[6:5], 1'b0}, r[31:16]);
		end

		$display("Checks: %0d, errors: %0d, write-backs: %0d, cycles: %0d",
			checks, errors, write_backs, cycle_cnt);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: tb/mem_system_properties.sv
module mem_system_properties import cache_geom_pkg::*; (
	input logic              clk,
	input logic              rst_n,
	input logic [addr_w-1:0] addr,
	input logic              rd,
	input logic              wr,
	input logic              done,
	input logic              stall,
	input logic              cache_hit,
	input logic              err,
	input ctrl_state_t       state
);

	timeunit 1ns;
	timeprecision 100ps;

	logic illegal;

	assign illegal = (rd & wr) | ((rd | wr) & addr[0]);  // Odd address or both strobes

	hit_needs_done: assert property (@(posedge clk) disable iff (!rst_n)
		cache_hit |-> done)
		else $error("cache_hit was high without done");

	done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done)
		else $error("done stayed high for more than one cycle");

	illegal_never_done: assert property (@(posedge clk) disable iff (!rst_n)
		illegal |-> !done)
		else $error("illegal request completed with done");

	// No state change on a rejected request
	illegal_stays_idle: assert property (@(posedge clk) disable iff (!rst_n)
		(illegal && state == st_idle) |=> state == st_idle)
		else $error("controller left idle on an illegal request");

	reset_quiet: assert property (@(posedge clk)
		!rst_n |=> (state == st_idle && !done && !cache_hit && !err && !stall))
		else $error("outputs not quiet or controller not idle after a reset edge");

endmodule

bind mem_system mem_system_properties u_props (
	.clk       (clk),
	.rst_n     (rst_n),
	.addr      (addr),
	.rd        (rd),
	.wr        (wr),
	.done      (done),
	.stall     (stall),
	.cache_hit (cache_hit),
	.err       (err),
	.state     (u_ctrl.state)
);

// File: design/mem_system.sv
module mem_system import cache_geom_pkg::*, bank_mem_pkg::*; #(
	parameter int mem_words = 32768
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [addr_w-1:0] addr,
	input  word_t             data_in,
	input  logic              rd,
	input  logic              wr,
	output word_t             data_out,
	output logic              done,
	output logic              stall,
	output logic              cache_hit,
	output logic              err
);

	cache_port_if cport ();
	mem_port_if   mport ();

	cache_ctrl u_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.addr      (addr),
		.data_in   (data_in),
		.rd        (rd),
		.wr        (wr),
		.data_out  (data_out),
		.done      (done),
		.stall     (stall),
		.cache_hit (cache_hit),
		.err       (err),
		.cport     (cport.ctrl),
		.mport     (mport.ctrl)
	);

	cache_array u_cache (
		.clk   (clk),
		.rst_n (rst_n),
		.port  (cport.array)
	);

	four_bank_mem #(.mem_words(mem_words)) u_mem (
		.clk   (clk),
		.rst_n (rst_n),
		.port  (mport.mem)
	);

endmodule

// File: design/cache_ctrl.sv
module cache_ctrl import cache_geom_pkg::*, bank_mem_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [addr_w-1:0] addr,
	input  word_t             data_in,
	input  logic              rd,
	input  logic              wr,
	output word_t             data_out,
	output logic              done,
	output logic              stall,
	output logic              cache_hit,
	output logic              err,
	cache_port_if.ctrl        cport,
	mem_port_if.ctrl          mport
);

	localparam int sel_w = offset_w - 1;
	localparam logic [sel_w-1:0] last_word = '1;

	ctrl_state_t        state;
	ctrl_state_t        state_nxt;
	logic [sel_w-1:0]   issue_cnt;  // Memory strobes accepted
	logic [sel_w-1:0]   recv_cnt;   // Fill words written to the cache
	logic [tag_w-1:0]   req_tag;
	logic [index_w-1:0] req_index;
	logic               legal;
	logic               filling;
	logic               issue_ok;
	logic               recv_ok;

	assign req_tag   = addr[addr_w-1 -: tag_w];
	assign req_index = addr[offset_w +: index_w];

	assign err      = (rd & wr) | ((rd | wr) & addr[0]);  // Odd address or both strobes
	assign legal    = (rd ^ wr) & ~addr[0];
	assign stall    = legal & ~done;
	assign data_out = cport.rdata;

	assign cport.index = req_index;
	assign cport.tag   = req_tag;

	// Victim tag during write-back, request tag for the fill
	assign mport.addr  = {(state == st_wb) ? cport.tag_out : req_tag, req_index, issue_cnt, 1'b0};
	assign mport.wdata = cport.rdata;

	assign filling  = (state == st_fill_issue) || (state == st_fill_wait);
	assign issue_ok = (mport.rd | mport.wr) & ~mport.stall;
	assign recv_ok  = filling & mport.rvalid;

	always_comb begin
		state_nxt      = state;
		cport.word_sel = addr[offset_w-1:1];
		cport.wdata    = data_in;
		cport.comp     = 1'b0;
		cport.write    = 1'b0;
		cport.valid_in = 1'b0;
		mport.wr       = 1'b0;
		mport.rd       = 1'b0;
		done           = 1'b0;
		cache_hit      = 1'b0;

		// Returning fill words go straight into the line
		if (filling) begin
			cport.word_sel = recv_cnt;
			cport.wdata    = mport.rdata;
			cport.write    = mport.rvalid;
			cport.valid_in = recv_cnt == last_word;  // Line valid once complete
		end

		case (state)
			st_idle: begin
				if (legal) begin
					state_nxt = st_compare;
				end
			end
			st_compare: begin
				cport.comp  = 1'b1;
				cport.write = wr;
				if (cport.hit) begin
					done      = 1'b1;
					cache_hit = 1'b1;
					state_nxt = st_idle;
				end else if (cport.valid && cport.dirty) begin
					state_nxt = st_wb;
				end else begin
					state_nxt = st_fill_issue;
				end
			end
			st_wb: begin
				cport.word_sel = issue_cnt;  // Victim word to memory
				mport.wr       = 1'b1;
				if (issue_ok && issue_cnt == last_word) begin
					state_nxt = st_fill_issue;
				end
			end
			st_fill_issue: begin
				mport.rd = 1'b1;
				if (issue_ok && issue_cnt == last_word) begin
					state_nxt = st_fill_wait;
				end
			end
			st_fill_wait: begin
				if (recv_ok && recv_cnt == last_word) begin
					state_nxt = st_done;
				end
			end
			st_done: begin
				cport.comp  = 1'b1;
				cport.write = wr;  // Merge write data and set dirty
				done        = 1'b1;
				state_nxt   = st_idle;
			end
			default: begin
				state_nxt = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= st_idle;
			issue_cnt <= '0;
			recv_cnt  <= '0;
		end else begin
			state <= state_nxt;
			if (state == st_compare) begin
				issue_cnt <= '0;
				recv_cnt  <= '0;
			end else begin
				if (issue_ok) begin
					issue_cnt <= issue_cnt + 1'b1;
				end
				if (recv_ok) begin
					recv_cnt <= recv_cnt + 1'b1;
				end
			end
		end
	end

endmodule

// File: design/four_bank_mem.sv
module four_bank_mem import bank_mem_pkg::*; #(
	parameter int mem_words = 32768
) (
	input  logic      clk,
	input  logic      rst_n,
	mem_port_if.mem   port
);

	localparam int bank_depth = mem_words / num_banks;
	localparam int row_w      = $clog2(bank_depth);
	localparam int sel_w      = $clog2(num_banks);
	localparam int cnt_w      = $clog2(bank_busy_cycles + 1);

	logic [sel_w-1:0]        bank;
	logic [row_w-1:0]        row;
	logic                    accept;
	word_t                   bank_rdata [num_banks];
	logic [read_latency-1:0] rv_pipe;
	word_t                   rd_pipe [read_latency];

	assign bank = port.addr[1 +: sel_w];          // Word interleave
	assign row  = port.addr[1 + sel_w +: row_w];  // Upper bits drop off for small depths

	assign port.stall = (port.rd | port.wr) & port.busy[bank];
	assign accept     = (port.rd | port.wr) & ~port.busy[bank];

	for (genvar b = 0; b < num_banks; b++) begin : g_bank
		logic [cnt_w-1:0] busy_cnt;
		logic             hit_bank;

		assign hit_bank     = accept & (bank == sel_w'(b));
		assign port.busy[b] = busy_cnt != '0;

		storage_ram #(.entry_t(word_t), .depth(bank_depth)) u_ram (
			.clk    (clk),
			.we     (hit_bank & port.wr),
			.waddr  (row),
			.wentry (port.wdata),
			.raddr  (row),
			.rentry (bank_rdata[b])
		);

		always_ff @(posedge clk) begin
			if (!rst_n) begin
				busy_cnt <= '0;
			end else if (hit_bank) begin
				busy_cnt <= cnt_w'(bank_busy_cycles);
			end else if (busy_cnt != '0) begin
				busy_cnt <= busy_cnt - 1'b1;
			end
		end
	end

	// Read return pipeline, several reads may overlap
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rv_pipe <= '0;
		end else begin
			rv_pipe <= (rv_pipe << 1) | read_latency'(accept & port.rd);
		end
	end

	always_ff @(posedge clk) begin
		rd_pipe[0] <= bank_rdata[bank];  // Sampled with the strobe
		for (int i = 1; i < read_latency; i++) begin
			rd_pipe[i] <= rd_pipe[i-1];
		end
	end

	assign port.rdata  = rd_pipe[read_latency-1];
	assign port.rvalid = rv_pipe[read_latency-1];

endmodule

// File: design/cache_array.sv
module cache_array import cache_geom_pkg::*, bank_mem_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	cache_port_if.array port
);

	localparam int lines = 1 << index_w;
	localparam int words = lines << (offset_w - 1);

	logic [lines-1:0] valid_vec;  // Cleared by reset, the RAM is not
	tag_entry_t       tag_rd;
	tag_entry_t       tag_wr;
	logic             fill_wr;
	logic             line_we;

	storage_ram #(.entry_t(tag_entry_t), .depth(lines)) u_tag_ram (
		.clk    (clk),
		.we     (line_we),
		.waddr  (port.index),
		.wentry (tag_wr),
		.raddr  (port.index),
		.rentry (tag_rd)
	);

	storage_ram #(.entry_t(word_t), .depth(words)) u_data_ram (
		.clk    (clk),
		.we     (line_we),
		.waddr  ({port.index, port.word_sel}),
		.wentry (port.wdata),
		.raddr  ({port.index, port.word_sel}),
		.rentry (port.rdata)
	);

	assign port.valid   = valid_vec[port.index] & tag_rd.valid;
	assign port.hit     = port.valid & (tag_rd.tag == port.tag);
	assign port.dirty   = port.valid & tag_rd.dirty;
	assign port.tag_out = tag_rd.tag;

	assign fill_wr = port.write & ~port.comp;
	assign line_we = fill_wr | (port.write & port.comp & port.hit);  // Compare writes only on hit

	always_comb begin
		tag_wr.tag = port.tag;
		if (port.comp) begin
			tag_wr.valid = 1'b1;
			tag_wr.dirty = 1'b1;  // Write hit marks the line dirty
		end else begin
			tag_wr.valid = port.valid_in;
			tag_wr.dirty = 1'b0;  // Fresh from memory
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_vec <= '0;
		end else if (fill_wr) begin
			valid_vec[port.index] <= port.valid_in;
		end
	end

endmodule

// File: design/storage_ram.sv
module storage_ram #(
	parameter type entry_t = logic [15:0],
	parameter int  depth   = 256
) (
	input  logic                     clk,
	input  logic                     we,
	input  logic [$clog2(depth)-1:0] waddr,
	input  entry_t                   wentry,
	input  logic [$clog2(depth)-1:0] raddr,
	output entry_t                   rentry
);

	// Zero at time zero so simulation never reads X
	entry_t mem [depth] = '{default: '0};

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wentry;
		end
	end

	assign rentry = mem[raddr];  // Asynchronous read

endmodule

// File: design/mem_port_if.sv
interface mem_port_if import bank_mem_pkg::*; ();

	logic [mem_addr_w-1:0] addr;
	word_t                 wdata;
	logic                  wr;     // Single-cycle strobe, held while stalled
	logic                  rd;

	word_t                 rdata;
	logic                  rvalid;
	logic [num_banks-1:0]  busy;
	logic                  stall;  // Strobe targets a busy bank

	modport ctrl (
		output addr, wdata, wr, rd,
		input  rdata, rvalid, busy, stall
	);

	modport mem (
		input  addr, wdata, wr, rd,
		output rdata, rvalid, busy, stall
	);

endinterface

// File: design/cache_port_if.sv
interface cache_port_if import cache_geom_pkg::*, bank_mem_pkg::*; ();

	logic [index_w-1:0]  index;
	logic [tag_w-1:0]    tag;
	logic [offset_w-2:0] word_sel;  // Word within the line
	word_t               wdata;
	logic                comp;      // Compare mode, else fill mode
	logic                write;
	logic                valid_in;  // Valid bit stored by a fill write

	logic                hit;
	logic                valid;
	logic                dirty;
	logic [tag_w-1:0]    tag_out;   // Tag currently held at index
	word_t               rdata;

	modport ctrl (
		output index, tag, word_sel, wdata, comp, write, valid_in,
		input  hit, valid, dirty, tag_out, rdata
	);

	modport array (
		input  index, tag, word_sel, wdata, comp, write, valid_in,
		output hit, valid, dirty, tag_out, rdata
	);

endinterface

// File: design/bank_mem_pkg.sv
package bank_mem_pkg;

	localparam int num_banks        = 4;   // Word interleaved on addr[2:1]
	localparam int bank_busy_cycles = 4;   // Bank blocked after each access
	localparam int read_latency     = 2;   // Strobe to rvalid
	localparam int mem_addr_w       = 16;  // Byte address into memory

	typedef logic [15:0] word_t;

endpackage

// File: design/cache_geom_pkg.sv
package cache_geom_pkg;

	localparam int tag_w    = 5;                           // Upper address bits
	localparam int index_w  = 8;                           // 256 lines
	localparam int offset_w = 3;                           // Byte within a 4-word line
	localparam int addr_w   = tag_w + index_w + offset_w;  // 16-bit byte address

	// One tag RAM entry per line
	typedef struct packed {
		logic [tag_w-1:0] tag;
		logic             valid;
		logic             dirty;                           // Line differs from memory
	} tag_entry_t;

	typedef enum logic [2:0] {
		st_idle,                                           // Wait for a legal request
		st_compare,                                        // Tag lookup, hit completes here
		st_wb,                                             // Dirty victim to memory
		st_fill_issue,                                     // Read strobes for the new line
		st_fill_wait,                                      // Last words still in flight
		st_done                                            // Repeat compare, merge write
	} ctrl_state_t;

endpackage
